/* logic/drop_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module drop_unit
        import fetch_pkg::*;
(
        input  logic  clk,
        input  logic  reset,

        // one-cycle request to throw away the next response
        input  logic  drop,

        // response stream from the memory
        input  logic  istream_val,
        input  inst_t istream_data,
        output logic  istream_rdy,

        // filtered stream toward the fetch unit
        output logic  ostream_val,
        output inst_t ostream_data,
        input  logic  ostream_rdy
);

        localparam logic state_pass = 1'b0;
        localparam logic state_drop = 1'b1;

        logic state_q;
        logic state_d;
        logic istream_go;
        logic in_pass;

        assign in_pass    = (state_q == state_pass);
        assign istream_go = istream_val && istream_rdy;

        // payload goes straight through and only the valid is filtered
        assign ostream_data = istream_data;

        // ==============================================================
        // stream control
        // ==============================================================

        // in pass the valid is a plain wire masked while drop is high
        // in drop anything is accepted and nothing shows downstream
        assign ostream_val = istream_val && !drop && in_pass;
        assign istream_rdy = ostream_rdy || !in_pass;

        // ==============================================================
        // state
        // ==============================================================

        always_comb begin
                state_d = state_q;
                if (in_pass) begin
                        // a response already here is eaten this cycle
                        // otherwise remember to eat the next one
                        if (drop && !istream_go) begin
                                state_d = state_drop;
                        end
                end else if (istream_go) begin
                        // stale response consumed
                        state_d = state_pass;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state_q <= state_pass;
                end else begin
                        state_q <= state_d;
                end
        end

        // a second squash before the stale response is gone would be lost
        drop_only_in_pass: assert property (@(posedge clk) disable iff (reset)
                drop |-> in_pass);

endmodule

`default_nettype wire

/* logic/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// ======================================================================
// fetch front end constants
// ======================================================================

// width of byte addresses and of instruction words
`define XLEN 32

// log2 of the instruction memory depth in words (256 words)
`define IMEM_IDX_BITS 8

// cycles from an accepted read request to a valid response, must be >= 1
`define IMEM_LATENCY 3

// first fetch address once reset is released
`define RESET_PC 32'h0000_0000

`endif

/* logic/fetch_pkg.sv */
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

        // ==============================================================
        // shared types of the fetch front end
        // ==============================================================

        // byte address, one word wide
        typedef logic [`XLEN-1:0] addr_t;

        // raw instruction word as returned by the memory
        typedef logic [`XLEN-1:0] inst_t;

        // word index into the instruction memory
        typedef logic [`IMEM_IDX_BITS-1:0] imem_idx_t;

        // word index from a byte address
        // byte offset bits are ignored, upper bits wrap around the array
        function automatic imem_idx_t addr_to_idx(input addr_t addr);
                return addr[`IMEM_IDX_BITS+1:2];
        endfunction

endpackage

`default_nettype wire

/* logic/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_top
        import fetch_pkg::*;
(
        input  logic      clk,
        input  logic      reset,

        // program load port
        input  logic      mem_wen,
        input  imem_idx_t mem_waddr,
        input  inst_t     mem_wdata,

        // redirect from later stages
        input  logic      redirect,
        input  addr_t     redirect_pc,

        // instruction stream to decode
        output logic      inst_val,
        output addr_t     inst_pc,
        output inst_t     inst_word,
        input  logic      inst_rdy
);

        // ==============================================================
        // internal streams
        // ==============================================================

        // fetch unit to memory
        logic  imemreq_val;
        addr_t imemreq_addr;
        logic  imemreq_rdy;

        // memory to drop unit
        logic  imemresp_val;
        inst_t imemresp_data;
        logic  imemresp_rdy;

        // drop unit to fetch unit
        logic  resp_val;
        inst_t resp_data;
        logic  resp_rdy;

        logic  drop;

        fetch_unit fetch_i (
                .clk         (clk),
                .reset       (reset),
                .redirect    (redirect),
                .redirect_pc (redirect_pc),
                .req_val     (imemreq_val),
                .req_addr    (imemreq_addr),
                .req_rdy     (imemreq_rdy),
                .resp_val    (resp_val),
                .resp_data   (resp_data),
                .resp_rdy    (resp_rdy),
                .drop        (drop),
                .inst_val    (inst_val),
                .inst_pc     (inst_pc),
                .inst_word   (inst_word),
                .inst_rdy    (inst_rdy)
        );

        imem_pipe imem_i (
                .clk       (clk),
                .reset     (reset),
                .mem_wen   (mem_wen),
                .mem_waddr (mem_waddr),
                .mem_wdata (mem_wdata),
                .req_val   (imemreq_val),
                .req_addr  (imemreq_addr),
                .req_rdy   (imemreq_rdy),
                .resp_val  (imemresp_val),
                .resp_data (imemresp_data),
                .resp_rdy  (imemresp_rdy)
        );

        // stale responses after a redirect die here
        drop_unit drop_i (
                .clk          (clk),
                .reset        (reset),
                .drop         (drop),
                .istream_val  (imemresp_val),
                .istream_data (imemresp_data),
                .istream_rdy  (imemresp_rdy),
                .ostream_val  (resp_val),
                .ostream_data (resp_data),
                .ostream_rdy  (resp_rdy)
        );

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_unit
        import fetch_pkg::*;
(
        input  logic  clk,
        input  logic  reset,

        // pc replacement from later stages
        input  logic  redirect,
        input  addr_t redirect_pc,

        // request stream to the instruction memory
        output logic  req_val,
        output addr_t req_addr,
        input  logic  req_rdy,

        // filtered response stream
        input  logic  resp_val,
        input  inst_t resp_data,
        output logic  resp_rdy,

        // squash of the response in flight
        output logic  drop,

        // instruction stream to decode
        output logic  inst_val,
        output addr_t inst_pc,
        output inst_t inst_word,
        input  logic  inst_rdy
);

        // fetch is allowed from the second cycle out of reset on
        logic run_q;

        // next address to request
        addr_t pc_q;

        // a request is out whose response is still wanted
        logic  live_q;
        addr_t live_pc_q;

        // output register
        logic  out_val_q;
        addr_t out_pc_q;
        inst_t out_word_q;

        logic req_go;
        logic resp_go;
        logic inst_go;

        // ==============================================================
        // request side
        // ==============================================================

        // one request at a time, and only into an empty output register
        assign req_val  = run_q && !live_q && !out_val_q && !redirect;
        assign req_addr = pc_q;
        assign req_go   = req_val && req_rdy;

        always_ff @(posedge clk) begin
                if (reset) begin
                        run_q <= 1'b0;
                end else begin
                        run_q <= 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        pc_q <= `RESET_PC;
                end else if (redirect) begin
                        pc_q <= redirect_pc;
                end else if (req_go) begin
                        pc_q <= pc_q + addr_t'(4);
                end
        end

        // ==============================================================
        // live request tracking
        // ==============================================================

        // a redirect with a request out makes its response stale
        assign drop = redirect && live_q;

        always_ff @(posedge clk) begin
                if (reset) begin
                        live_q <= 1'b0;
                end else if (redirect || resp_go) begin
                        live_q <= 1'b0;
                end else if (req_go) begin
                        live_q <= 1'b1;
                end
        end

        // pc tag that goes along with the response
        always_ff @(posedge clk) begin
                if (req_go) begin
                        live_pc_q <= pc_q;
                end
        end

        // ==============================================================
        // response capture and output register
        // ==============================================================

        assign resp_rdy = !out_val_q;
        assign resp_go  = resp_val && resp_rdy;
        assign inst_go  = out_val_q && inst_rdy;

        always_ff @(posedge clk) begin
                if (reset) begin
                        out_val_q <= 1'b0;
                end else if (redirect) begin
                        // anything not taken by now belongs to the old path
                        out_val_q <= 1'b0;
                end else if (resp_go) begin
                        out_val_q <= 1'b1;
                end else if (inst_go) begin
                        out_val_q <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (resp_go) begin
                        out_pc_q   <= live_pc_q;
                        out_word_q <= resp_data;
                end
        end

        assign inst_val  = out_val_q;
        assign inst_pc   = out_pc_q;
        assign inst_word = out_word_q;

        // whatever gets past the drop unit belongs to the live request
        resp_is_live: assert property (@(posedge clk) disable iff (reset)
                resp_val |-> live_q);

endmodule

`default_nettype wire

/* logic/imem_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module imem_pipe
        import fetch_pkg::*;
(
        input  logic      clk,
        input  logic      reset,

        // load port that works at any time including reset
        input  logic      mem_wen,
        input  imem_idx_t mem_waddr,
        input  inst_t     mem_wdata,

        // read request stream
        input  logic      req_val,
        input  addr_t     req_addr,
        output logic      req_rdy,

        // read response stream
        output logic      resp_val,
        output inst_t     resp_data,
        input  logic      resp_rdy
);

        localparam int mem_words = 1 << `IMEM_IDX_BITS;
        localparam int lat_bits  = $clog2(`IMEM_LATENCY + 1);

        inst_t mem [0:mem_words-1];

        // one read in flight at most
        logic busy_q;

        // cycles left before the response shows up
        logic [lat_bits-1:0] count_q;

        // word read at request time and held until the response is taken
        inst_t data_q;

        logic req_go;
        logic resp_go;

        assign req_go  = req_val && req_rdy;
        assign resp_go = resp_val && resp_rdy;

        // ==============================================================
        // storage
        // ==============================================================

        always_ff @(posedge clk) begin
                if (mem_wen) begin
                        mem[mem_waddr] <= mem_wdata;
                end
        end

        // array is sampled when the request is accepted
        always_ff @(posedge clk) begin
                if (req_go) begin
                        data_q <= mem[addr_to_idx(req_addr)];
                end
        end

        // ==============================================================
        // latency tracking
        // ==============================================================

        always_ff @(posedge clk) begin
                if (reset) begin
                        busy_q <= 1'b0;
                end else if (req_go) begin
                        busy_q <= 1'b1;
                end else if (resp_go) begin
                        busy_q <= 1'b0;
                end
        end

        // loaded with latency-1 so resp_val rises exactly latency cycles later
        always_ff @(posedge clk) begin
                if (reset) begin
                        count_q <= '0;
                end else if (req_go) begin
                        count_q <= lat_bits'(`IMEM_LATENCY - 1);
                end else if (busy_q && (count_q != '0)) begin
                        count_q <= count_q - 1'b1;
                end
        end

        // no new request until the current response has been taken
        assign req_rdy = !busy_q;

        // response sits here until the consumer takes it
        assign resp_val  = busy_q && (count_q == '0);
        assign resp_data = data_q;

        // the response is waiting once the latency has run out
        resp_on_time: assert property (@(posedge clk) disable iff (reset)
                req_go |-> ##(`IMEM_LATENCY) resp_val);

endmodule

`default_nettype wire

/* verification/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_params.svh"

module fetch_tb
        import fetch_pkg::*;
();

        localparam int mem_words = 1 << `IMEM_IDX_BITS;
        // sequential, stall, in-flight redirects, random redirects, wrap
        localparam int n_insts = 40 + 40 + 4 + 300 + 10;
        // stalls up to 8 cycles each, a redirect can cost up to 16 cycles
        localparam int watchdog_cycles = 2 * n_insts * (`IMEM_LATENCY + 6)
                + 340 * 8 + 300 * 16 + 16 + mem_words;

        logic      clk;
        logic      reset;
        logic      mem_wen;
        imem_idx_t mem_waddr;
        inst_t     mem_wdata;
        logic      redirect;
        addr_t     redirect_pc;
        logic      inst_val;
        addr_t     inst_pc;
        inst_t     inst_word;
        logic      inst_rdy;

        // copy of the program held in the memory
        inst_t       image [0:mem_words-1];
        // reference model, pc of the next instruction decode should see
        addr_t       exp_pc;
        logic [15:0] lfsr_q;
        int          check_errors;
        int          other_errors;

        fetch_top dut_i (
                .clk         (clk),
                .reset       (reset),
                .mem_wen     (mem_wen),
                .mem_waddr   (mem_waddr),
                .mem_wdata   (mem_wdata),
                .redirect    (redirect),
                .redirect_pc (redirect_pc),
                .inst_val    (inst_val),
                .inst_pc     (inst_pc),
                .inst_word   (inst_word),
                .inst_rdy    (inst_rdy)
        );

        always #50 clk = ~clk;

        // ==================================================================
        // helpers
        // ==================================================================

        // x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic lfsr_step();
                logic fb;
                fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
                lfsr_q = {lfsr_q[14:0], fb};
                return fb;
        endfunction

        // one lfsr step per bit
        function automatic logic [31:0] random_bits(input int n);
                logic [31:0] v;
                int          i;
                v = '0;
                for (i = 0; i < n; i++) begin
                        v = {v[30:0], lfsr_step()};
                end
                return v;
        endfunction

        // word for a byte address, index wraps every 1024 bytes
        function automatic inst_t image_word(input addr_t pc);
                return image[(pc / 4) % mem_words];
        endfunction

        task automatic compare_addr(input string test, input addr_t expected, input addr_t actual);
                if (expected !== actual) begin
                        check_errors++;
                        $display("CHECK FAILED %s: pc expected %h actual %h", test, expected, actual);
                end
        endtask

        task automatic compare_inst(input string test, input inst_t expected, input inst_t actual);
                if (expected !== actual) begin
                        check_errors++;
                        $display("CHECK FAILED %s: word expected %h actual %h", test, expected,
                                actual);
                end
        endtask

        // called on a falling edge, covers one clock cycle
        task automatic drive_cycle(input string test, input logic rdy, input logic redir,
                        input addr_t target, output logic took);
                inst_rdy    = rdy;
                redirect    = redir;
                redirect_pc = target;
                took        = 1'b0;
                // a shown instruction must match the model, stalled or not
                if (inst_val) begin
                        compare_addr(test, exp_pc, inst_pc);
                        compare_inst(test, image_word(exp_pc), inst_word);
                        if (rdy) begin
                                took   = 1'b1;
                                exp_pc = exp_pc + 32'd4;
                        end
                end
                // an instruction taken with the redirect still counts
                if (redir) begin
                        exp_pc = target;
                end
                @(negedge clk);
                // park so that no handshake happens unobserved
                inst_rdy = 1'b0;
                redirect = 1'b0;
        endtask

        task automatic wait_inst(input string test, output logic ok);
                int   n;
                logic took;
                n = 0;
                while (!inst_val && n < 16 * (`IMEM_LATENCY + 6)) begin
                        drive_cycle(test, 1'b0, 1'b0, '0, took);
                        n++;
                end
                ok = inst_val;
                if (!ok) begin
                        other_errors++;
                        $display("%s: inst_val never rose within %0d cycles", test, n);
                end
        endtask

        // optional random stalls and random redirects until n deliveries
        task automatic run_deliveries(input string test, input int n, input logic stalls,
                        input logic redirects);
                int    got;
                int    cycles;
                int    stall_left;
                logic  rdy;
                logic  redir;
                logic  took;
                addr_t target;
                got        = 0;
                cycles     = 0;
                stall_left = 0;
                while (got < n && cycles < n * 4 * (`IMEM_LATENCY + 6) + 64) begin
                        rdy    = 1'b1;
                        redir  = 1'b0;
                        target = '0;
                        if (stalls && stall_left > 0) begin
                                rdy = 1'b0;
                                stall_left--;
                        end else if (stalls && random_bits(2) == 0) begin
                                rdy        = 1'b0;
                                stall_left = random_bits(3);
                        end
                        // targets up to 4092 also cross the wrap point
                        if (redirects && random_bits(4) == 0) begin
                                redir  = 1'b1;
                                target = addr_t'(random_bits(10)) << 2;
                        end
                        drive_cycle(test, rdy, redir, target, took);
                        if (took) begin
                                got++;
                        end
                        cycles++;
                end
                if (got < n) begin
                        other_errors++;
                        $display("%s: only %0d of %0d instructions came out in %0d cycles",
                                test, got, n, cycles);
                end
        endtask

        // ==================================================================
        // directed tests
        // ==================================================================

        // first 16 words during reset, rest while decode holds the first
        task automatic load_and_reset();
                int i;
                for (i = 0; i < mem_words; i++) begin
                        if (i == 16) begin
                                reset = 1'b0;
                        end
                        if (i < 18 && inst_val) begin
                                other_errors++;
                                $display("reset: inst_val high in or right after reset");
                        end
                        mem_wen   = 1'b1;
                        mem_waddr = imem_idx_t'(i);
                        mem_wdata = image[i];
                        @(negedge clk);
                end
                mem_wen = 1'b0;
        endtask

        task automatic first_fetch();
                logic ok;
                wait_inst("reset", ok);
                compare_addr("reset", `RESET_PC, inst_pc);
                compare_inst("reset", image[0], inst_word);
        endtask

        // redirect lands two cycles after an accept, while the read is out
        task automatic redirect_in_flight(input string test, input addr_t target);
                logic took;
                logic ok;
                int   n;
                took = 1'b0;
                n    = 0;
                while (!took && n < 16 * (`IMEM_LATENCY + 6)) begin
                        drive_cycle(test, 1'b1, 1'b0, '0, took);
                        n++;
                end
                if (!took) begin
                        other_errors++;
                        $display("%s: no instruction accepted before the redirect", test);
                end else begin
                        // next request leaves in this cycle
                        drive_cycle(test, 1'b1, 1'b0, '0, took);
                        drive_cycle(test, 1'b1, 1'b1, target, took);
                        wait_inst(test, ok);
                        compare_addr(test, target, inst_pc);
                        compare_inst(test, image_word(target), inst_word);
                        run_deliveries(test, 1, 1'b0, 1'b0);
                end
        endtask

        // 1008 onward runs through index 255 and back to 0
        task automatic wrap_fetch();
                logic took;
                drive_cycle("wrap", 1'b0, 1'b1, 32'd1008, took);
                run_deliveries("wrap", 10, 1'b0, 1'b0);
        endtask

        initial begin
                int i;
                clk          = 1'b0;
                reset        = 1'b1;
                mem_wen      = 1'b0;
                mem_waddr    = '0;
                mem_wdata    = '0;
                redirect     = 1'b0;
                redirect_pc  = '0;
                inst_rdy     = 1'b0;
                lfsr_q       = 16'd39;
                check_errors = 0;
                other_errors = 0;
                exp_pc       = `RESET_PC;
                for (i = 0; i < mem_words; i++) begin
                        image[i] = random_bits(32);
                end
                load_and_reset();
                first_fetch();
                run_deliveries("sequential", 40, 1'b0, 1'b0);
                run_deliveries("stall", 40, 1'b1, 1'b0);
                for (i = 0; i < 4; i++) begin
                        redirect_in_flight("in-flight redirect", addr_t'(random_bits(8)) << 2);
                end
                run_deliveries("random redirect", 300, 1'b1, 1'b1);
                wrap_fetch();
                $display("%0d value mismatches, %0d other failures", check_errors,
                        other_errors);
                if (check_errors == 0 && other_errors == 0) begin
                        $display("Regression passed");
                end else begin
                        $display("Regression failed");
                end
                $finish;
        end

        // hard stop in case the front end locks up
        initial begin
                repeat (watchdog_cycles) @(posedge clk);
                $display("watchdog: run still going after %0d cycles", watchdog_cycles);
                $display("%0d value mismatches, %0d other failures", check_errors,
                        other_errors);
                $display("Regression failed");
                $finish;
        end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+logic
logic/fetch_pkg.sv
logic/drop_unit.sv
logic/imem_pipe.sv
logic/fetch_unit.sv
logic/fetch_top.sv
verification/fetch_tb.sv
